//--- source/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// architectural register file
`define REG_NUM 32
`define REG_W 5

// result and jump target widths
`define DATA_W 32
`define ADDR_W 32

// reorder buffer, slot 0 means no tag
`define ROB_DEPTH 32
`define NICK_W 5

`endif

//--- source/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_STORE  = 2'd2
    } entry_kind_e;

    // what the head does this cycle
    typedef enum logic [2:0] {
        ACT_NONE       = 3'd0,
        ACT_REG        = 3'd1,
        ACT_RELEASE    = 3'd2,
        ACT_STORE_DONE = 3'd3,
        ACT_FLUSH      = 3'd4
    } commit_act_e;

    typedef struct packed {
        logic [`REG_W-1:0] rd;
        entry_kind_e       kind;
        logic              pred_taken;
    } dispatch_t;

    typedef struct packed {
        logic [`NICK_W-1:0] nick;
        logic [`DATA_W-1:0] data;
        logic               taken;
        logic [`ADDR_W-1:0] target;
    } exec_wb_t;

    typedef struct packed {
        logic [`NICK_W-1:0] nick;
        logic [`REG_W-1:0]  rd;
        logic [`DATA_W-1:0] data;
    } commit_t;

    typedef struct packed {
        logic               busy;
        logic               done;
        logic               released;
        entry_kind_e        kind;
        logic               pred_taken;
        logic               act_taken;
        logic [`REG_W-1:0]  rd;
        logic [`DATA_W-1:0] data;
        logic [`ADDR_W-1:0] target;
    } rob_slot_t;

    // next tag, wraps past slot 0
    function automatic logic [`NICK_W-1:0] nick_inc(input logic [`NICK_W-1:0] nick);
        logic [`NICK_W-1:0] next;
        if (nick == `NICK_W'(`ROB_DEPTH - 1)) begin
            next = `NICK_W'd1;
        end else begin
            next = nick + 1'b1;
        end
        return next;
    endfunction

endpackage

//--- source/rob_entries.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rob_entries (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 disp_en,
    input  rob_pkg::dispatch_t   disp,
    input  logic                 wb_en,
    input  rob_pkg::exec_wb_t    wb,
    input  logic                 store_done_en,
    input  logic [`NICK_W-1:0]   store_done_nick,
    input  logic [`NICK_W-1:0]   head_ptr,
    input  logic                 retire,
    input  logic                 release_set,
    input  logic                 flush,
    output logic [`NICK_W-1:0]   disp_nick,
    output logic                 full,
    output rob_pkg::rob_slot_t   head_slot,
    output logic                 head_busy
);
    import rob_pkg::*;

    rob_slot_t          slots [`ROB_DEPTH];
    logic [`NICK_W-1:0] tail;
    logic [`NICK_W-1:0] count;
    logic               disp_ok;

    assign disp_ok   = disp_en && !full;
    assign disp_nick = tail;

    // one slot is lost to the no-tag value
    assign full = (count == `NICK_W'(`ROB_DEPTH - 1));

    assign head_slot = slots[head_ptr];
    assign head_busy = (count != '0) && slots[head_ptr].busy;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                slots[i].busy     <= 1'b0;
                slots[i].done     <= 1'b0;
                slots[i].released <= 1'b0;
            end
            tail  <= `NICK_W'd1;
            count <= '0;
        end else begin
            // memory side took the store
            if (store_done_en) begin
                slots[store_done_nick].done <= 1'b1;
            end

            if (wb_en) begin
                slots[wb.nick].done      <= 1'b1;
                slots[wb.nick].data      <= wb.data;
                slots[wb.nick].act_taken <= wb.taken;
                slots[wb.nick].target    <= wb.target;
            end

            if (release_set) begin
                slots[head_ptr].released <= 1'b1;
            end

            if (retire) begin
                slots[head_ptr].busy     <= 1'b0;
                slots[head_ptr].done     <= 1'b0;
                slots[head_ptr].released <= 1'b0;
            end

            if (disp_ok) begin
                slots[tail] <= '{
                    busy:       1'b1,
                    done:       1'b0,
                    released:   1'b0,
                    kind:       disp.kind,
                    pred_taken: disp.pred_taken,
                    act_taken:  1'b0,
                    rd:         disp.rd,
                    data:       '0,
                    target:     '0
                };
                tail <= nick_inc(tail);
            end

            case ({disp_ok, retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // the front end must honor full
    a_no_disp_when_full: assert property (
        @(posedge clk) disable iff (rst)
        !(disp_en && full)
    );

    // results only for tags still in flight
    a_wb_to_busy_slot: assert property (
        @(posedge clk) disable iff (rst || flush)
        wb_en |-> slots[wb.nick].busy
    );

endmodule

//--- source/rob_commit.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rob_commit (
    input  logic                 clk,
    input  logic                 rst,
    input  rob_pkg::rob_slot_t   head_slot,
    input  logic                 head_busy,
    input  logic                 store_done_en,
    input  logic [`NICK_W-1:0]   store_done_nick,
    output logic [`NICK_W-1:0]   head_ptr,
    output logic                 retire,
    output logic                 release_set,
    output logic                 reg_wr_en,
    output rob_pkg::commit_t     reg_wr,
    output logic                 store_rel_en,
    output logic [`NICK_W-1:0]   store_rel_nick,
    output logic                 flush,
    output logic [`ADDR_W-1:0]   redirect_pc
);
    import rob_pkg::*;

    commit_act_e action;
    logic        store_hit;
    logic        mispredict;

    assign store_hit  = store_done_en && (store_done_nick == head_ptr);
    assign mispredict = (head_slot.kind == KIND_BRANCH)
                        && (head_slot.pred_taken != head_slot.act_taken);

    always_comb begin
        action = ACT_NONE;
        if (head_busy) begin
            if (head_slot.kind == KIND_STORE) begin
                if (!head_slot.released) begin
                    action = ACT_RELEASE;
                end else if (head_slot.done || store_hit) begin
                    action = ACT_STORE_DONE;
                end
            end else if (head_slot.done) begin
                if (mispredict) begin
                    action = ACT_FLUSH;
                end else begin
                    action = ACT_REG;
                end
            end
        end
    end

    assign retire      = (action == ACT_REG) || (action == ACT_STORE_DONE);
    assign release_set = (action == ACT_RELEASE);
    assign flush       = (action == ACT_FLUSH);

    // a mispredicted jal still links
    assign reg_wr_en = ((action == ACT_REG) || (action == ACT_FLUSH))
                       && (head_slot.rd != '0);
    assign reg_wr    = '{nick: head_ptr, rd: head_slot.rd, data: head_slot.data};

    assign store_rel_en   = release_set;
    assign store_rel_nick = head_ptr;
    assign redirect_pc    = head_slot.target;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= `NICK_W'd1;
        end else if (retire) begin
            head_ptr <= nick_inc(head_ptr);
        end
    end

    a_flush_not_release: assert property (
        @(posedge clk) disable iff (rst)
        !(flush && store_rel_en)
    );

    // released bit must stick in the entry store
    a_release_once: assert property (
        @(posedge clk) disable iff (rst)
        store_rel_en |=> !(store_rel_en && (store_rel_nick == $past(store_rel_nick)))
    );

endmodule

//--- source/rename_table.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rename_table (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 disp_en,
    input  rob_pkg::dispatch_t   disp,
    input  logic [`NICK_W-1:0]   disp_nick,
    input  logic                 reg_wr_en,
    input  rob_pkg::commit_t     reg_wr,
    input  logic                 flush,
    input  logic [`REG_W-1:0]    rs1,
    input  logic [`REG_W-1:0]    rs2,
    output logic [`NICK_W-1:0]   rs1_nick,
    output logic [`NICK_W-1:0]   rs2_nick
);
    import rob_pkg::*;

    logic [`NICK_W-1:0] tags [`REG_NUM];
    logic               maps_rd;

    // stores and x0 never own a register
    assign maps_rd = disp_en && (disp.rd != '0) && (disp.kind != KIND_STORE);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                tags[i] <= '0;
            end
        end else begin
            // only the youngest writer may clear the entry
            if (reg_wr_en && (tags[reg_wr.rd] == reg_wr.nick)) begin
                tags[reg_wr.rd] <= '0;
            end
            // new mapping wins over a same-cycle retire
            if (maps_rd) begin
                tags[disp.rd] <= disp_nick;
            end
        end
    end

    assign rs1_nick = (rs1 == '0) ? '0 : tags[rs1];
    assign rs2_nick = (rs2 == '0) ? '0 : tags[rs2];

endmodule

//--- source/rob_unit.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rob_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 disp_en,
    input  rob_pkg::dispatch_t   disp,
    output logic [`NICK_W-1:0]   disp_nick,
    output logic                 full,
    input  logic [`REG_W-1:0]    rs1,
    input  logic [`REG_W-1:0]    rs2,
    output logic [`NICK_W-1:0]   rs1_nick,
    output logic [`NICK_W-1:0]   rs2_nick,
    input  logic                 wb_en,
    input  rob_pkg::exec_wb_t    wb,
    input  logic                 store_done_en,
    input  logic [`NICK_W-1:0]   store_done_nick,
    output logic                 reg_wr_en,
    output rob_pkg::commit_t     reg_wr,
    output logic                 store_rel_en,
    output logic [`NICK_W-1:0]   store_rel_nick,
    output logic                 flush,
    output logic [`ADDR_W-1:0]   redirect_pc
);
    import rob_pkg::*;

    rob_slot_t           head_slot;
    logic                head_busy;
    logic [`NICK_W-1:0]  head_ptr;
    logic                retire;
    logic                release_set;

    rob_entries u_entries (
        .clk             (clk),
        .rst             (rst),
        .disp_en         (disp_en),
        .disp            (disp),
        .wb_en           (wb_en),
        .wb              (wb),
        .store_done_en   (store_done_en),
        .store_done_nick (store_done_nick),
        .head_ptr        (head_ptr),
        .retire          (retire),
        .release_set     (release_set),
        .flush           (flush),
        .disp_nick       (disp_nick),
        .full            (full),
        .head_slot       (head_slot),
        .head_busy       (head_busy)
    );

    rob_commit u_commit (
        .clk             (clk),
        .rst             (rst),
        .head_slot       (head_slot),
        .head_busy       (head_busy),
        .store_done_en   (store_done_en),
        .store_done_nick (store_done_nick),
        .head_ptr        (head_ptr),
        .retire          (retire),
        .release_set     (release_set),
        .reg_wr_en       (reg_wr_en),
        .reg_wr          (reg_wr),
        .store_rel_en    (store_rel_en),
        .store_rel_nick  (store_rel_nick),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

    rename_table u_rename (
        .clk       (clk),
        .rst       (rst),
        .disp_en   (disp_en),
        .disp      (disp),
        .disp_nick (disp_nick),
        .reg_wr_en (reg_wr_en),
        .reg_wr    (reg_wr),
        .flush     (flush),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_nick  (rs1_nick),
        .rs2_nick  (rs2_nick)
    );

endmodule

//--- tb/tb_rob_unit.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module tb_rob_unit;
    import rob_pkg::*;

    logic               clk;
    logic               rst;
    logic               disp_en;
    logic               wb_en;
    logic               store_done_en;
    logic               full;
    logic               reg_wr_en;
    logic               store_rel_en;
    logic               flush;
    dispatch_t          disp;
    exec_wb_t           wb;
    commit_t            reg_wr;
    logic [`REG_W-1:0]  rs1;
    logic [`REG_W-1:0]  rs2;
    logic [`NICK_W-1:0] disp_nick;
    logic [`NICK_W-1:0] rs1_nick;
    logic [`NICK_W-1:0] rs2_nick;
    logic [`NICK_W-1:0] store_done_nick;
    logic [`NICK_W-1:0] store_rel_nick;
    logic [`ADDR_W-1:0] redirect_pc;

    // reference model slots indexed by tag with order holding tags oldest first
    rob_slot_t   m_slot [`ROB_DEPTH];
    int          m_map [`REG_NUM];
    int          order [$];
    int          m_tail;
    logic [31:0] seed;
    int          mismatches;
    int          other_errors;
    int          drain_cycles;

    rob_unit dut0 (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 15);
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_nick(input string name, input logic [`NICK_W-1:0] got,
                              input logic [`NICK_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_commit(input string name, input commit_t got, input commit_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_flush(input string name, input logic [`ADDR_W-1:0] got,
                               input logic [`ADDR_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // check outputs after the edge, drive new inputs, then advance the model by one edge
    task automatic run_cycle(input bit allow_disp);
        int          h;
        int          pick;
        int          pend [$];
        bit          exp_wr;
        bit          exp_rel;
        bit          exp_flush;
        bit          do_retire;
        logic [31:0] r;
        commit_t     exp_c;
        h = 0;
        pick = 0;
        exp_wr = 0;
        exp_rel = 0;
        exp_flush = 0;
        do_retire = 0;
        @(negedge clk);
        if (order.size() > 0) begin
            h = order[0];
            if (m_slot[h].kind == KIND_STORE) begin
                exp_rel = !m_slot[h].released;
            end else if (m_slot[h].done) begin
                exp_flush = (m_slot[h].kind == KIND_BRANCH)
                            && (m_slot[h].pred_taken != m_slot[h].act_taken);
                exp_wr = (m_slot[h].rd != '0);
                do_retire = !exp_flush;
            end
        end
        exp_c = '{nick: `NICK_W'(h), rd: m_slot[h].rd, data: m_slot[h].data};
        check_bit("reg_wr_en", reg_wr_en, exp_wr);
        if (exp_wr) check_commit("reg_wr", reg_wr, exp_c);
        check_bit("store_rel_en", store_rel_en, exp_rel);
        if (exp_rel) check_nick("store_rel_nick", store_rel_nick, `NICK_W'(h));
        check_bit("flush", flush, exp_flush);
        if (exp_flush) check_flush("redirect_pc", redirect_pc, m_slot[h].target);
        check_bit("full", full, order.size() == `ROB_DEPTH - 1);
        check_nick("disp_nick", disp_nick, `NICK_W'(m_tail));
        check_nick("rs1_nick", rs1_nick, `NICK_W'(m_map[rs1]));
        check_nick("rs2_nick", rs2_nick, `NICK_W'(m_map[rs2]));

        disp_en = 1'b0;
        wb_en = 1'b0;
        store_done_en = 1'b0;
        rs1 = `REG_W'(next_rand() % 8);
        rs2 = `REG_W'(next_rand() % 8);
        if (!exp_flush) begin
            r = next_rand();
            if (allow_disp && order.size() < `ROB_DEPTH - 1 && r % 8 != 0) begin
                disp_en = 1'b1;
                disp.rd = `REG_W'((r >> 4) % 8);
                disp.pred_taken = r[12];
                if ((r >> 8) % 16 == 0) disp.kind = KIND_BRANCH;
                else if ((r >> 8) % 16 < 3) disp.kind = KIND_STORE;
                else disp.kind = KIND_ALU;
            end
            foreach (order[i]) begin
                if (m_slot[order[i]].kind != KIND_STORE && !m_slot[order[i]].done)
                    pend.push_back(order[i]);
            end
            r = next_rand();
            if (pend.size() > 0 && r % 2 == 0) begin
                // oldest pending now and then so the head keeps moving
                pick = (r[3:1] == 3'd0) ? pend[0] : pend[(r >> 4) % pend.size()];
                wb_en = 1'b1;
                wb.nick = `NICK_W'(pick);
                wb.taken = (r[11:8] == 4'd0) ? !m_slot[pick].pred_taken : m_slot[pick].pred_taken;
                wb.data = next_rand();
                wb.target = next_rand();
            end
            if (order.size() > 0 && m_slot[h].kind == KIND_STORE && m_slot[h].released
                && next_rand() % 3 == 0) begin
                store_done_en = 1'b1;
                store_done_nick = `NICK_W'(h);
                do_retire = 1'b1;
            end
        end

        if (exp_flush) begin
            order.delete();
            m_tail = 1;
            foreach (m_map[i]) m_map[i] = 0;
        end else begin
            if (exp_rel) m_slot[h].released = 1'b1;
            if (wb_en) begin
                m_slot[pick].done = 1'b1;
                m_slot[pick].data = wb.data;
                m_slot[pick].act_taken = wb.taken;
                m_slot[pick].target = wb.target;
            end
            if (do_retire) begin
                if (exp_wr && m_map[m_slot[h].rd] == h) m_map[m_slot[h].rd] = 0;
                void'(order.pop_front());
            end
            if (disp_en) begin
                m_slot[m_tail] = '{busy: 1'b1, kind: disp.kind, pred_taken: disp.pred_taken,
                                   rd: disp.rd, default: '0};
                if (disp.rd != '0 && disp.kind != KIND_STORE) m_map[disp.rd] = m_tail;
                order.push_back(m_tail);
                m_tail = (m_tail == `ROB_DEPTH - 1) ? 1 : m_tail + 1;
            end
        end
    endtask

    initial begin
        seed = 32'h542e7da5;
        mismatches = 0;
        other_errors = 0;
        clk = 1'b0;
        rst = 1'b1;
        disp_en = 1'b0;
        disp = '0;
        rs1 = '0;
        rs2 = '0;
        wb_en = 1'b0;
        wb = '0;
        store_done_en = 1'b0;
        store_done_nick = '0;
        m_tail = 1;
        foreach (m_map[i]) m_map[i] = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4000) run_cycle(1'b1);
        // no new work while the buffer empties
        drain_cycles = 0;
        while (order.size() > 0 && drain_cycles < 1000) begin
            run_cycle(1'b0);
            drain_cycles++;
        end
        if (order.size() > 0) begin
            other_errors++;
            $display("timeout: reorder buffer still holds %0d entries after draining",
                     order.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- rob_unit.f
+incdir+source
source/rob_pkg.sv
source/rob_entries.sv
source/rob_commit.sv
source/rename_table.sv
source/rob_unit.sv
tb/tb_rob_unit.sv
